/* Bender.yml */
package:
  name: retire_subsys

sources:
  - files:
      - common/core_cfg_pkg.sv
      - common/rob_types_pkg.sv
      - rob/rob_alloc.sv
      - rob/rob.sv
      - hdl/gshare_pht.sv
      - hdl/retire_top.sv
  - target: test
    files:
      - tb/retire_tb.sv

/* common/core_cfg_pkg.sv */
package core_cfg_pkg;

    // reorder buffer sizing
    localparam int ROB_NUM = 16;
    localparam int ROB_SEL = 4;

    // entry tag
    typedef logic [ROB_SEL-1:0] rob_tag_t;

    // free entries, 0 to ROB_NUM
    typedef logic [ROB_SEL:0] rob_cnt_t;

    // instruction address
    localparam int ADDR_LEN = 32;
    typedef logic [ADDR_LEN-1:0] addr_t;

    // architectural register number
    localparam int REG_SEL = 5;
    typedef logic [REG_SEL-1:0] areg_t;

    // global branch history
    localparam int BHR_LEN = 8;
    typedef logic [BHR_LEN-1:0] bhr_t;

    // pattern history table depth, one counter per history index
    localparam int PHT_NUM = 256;

endpackage

/* common/rob_types_pkg.sv */
package rob_types_pkg;

    // one dispatched instruction
    typedef struct packed {
        logic                valid;
        core_cfg_pkg::addr_t pc;
        logic                is_store;
        logic                dst_valid;
        core_cfg_pkg::areg_t dst;
        logic                is_branch;
        core_cfg_pkg::bhr_t  bhr;
    } dispatch_req_t;

    // done report from alu, mul or ld/st unit
    typedef struct packed {
        logic                   valid;
        core_cfg_pkg::rob_tag_t tag;
    } finish_rpt_t;

    // branch unit done, with resolved outcome
    typedef struct packed {
        logic                   valid;
        core_cfg_pkg::rob_tag_t tag;
        logic                   taken;
        core_cfg_pkg::addr_t    target;
    } branch_fin_t;

    // one retiring instruction
    typedef struct packed {
        logic                valid;
        logic                arf_we;
        core_cfg_pkg::areg_t dst;
        logic                is_store;
    } commit_t;

    // committed branch, trains the predictor
    typedef struct packed {
        logic                valid;
        core_cfg_pkg::addr_t pc;
        core_cfg_pkg::bhr_t  bhr;
        logic                taken;
        core_cfg_pkg::addr_t target;
    } br_train_t;

endpackage

/* hdl/gshare_pht.sv */
`timescale 1ns/100ps

module gshare_pht (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  rob_types_pkg::br_train_t train_i,
    input  core_cfg_pkg::addr_t      pred_pc_i,
    input  core_cfg_pkg::bhr_t       pred_bhr_i,
    output logic                     pred_taken_o
);
    import core_cfg_pkg::*;

    typedef logic [1:0] ctr_t;

    ctr_t pht_q [PHT_NUM];
    bhr_t pred_idx;
    bhr_t train_idx;
    ctr_t train_ctr;

    // pc bits above the word offset, folded with history
    assign pred_idx  = pred_pc_i[BHR_LEN+1:2] ^ pred_bhr_i;
    assign train_idx = train_i.pc[BHR_LEN+1:2] ^ train_i.bhr;
    assign train_ctr = pht_q[train_idx];

    // msb of the counter, old value on a same-cycle update
    assign pred_taken_o = pht_q[pred_idx][1];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            // weakly not taken
            for (int i = 0; i < PHT_NUM; i++) begin
                pht_q[i] <= 2'b01;
            end
        end else if (train_i.valid) begin
            // saturating two-bit counter
            if (train_i.taken && train_ctr != 2'b11) begin
                pht_q[train_idx] <= train_ctr + ctr_t'(1);
            end else if (!train_i.taken && train_ctr != 2'b00) begin
                pht_q[train_idx] <= train_ctr - ctr_t'(1);
            end
        end
    end

endmodule

/* hdl/retire_top.sv */
`timescale 1ns/100ps

module retire_top (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  rob_types_pkg::dispatch_req_t [1:0]   dispatch_i,
    input  rob_types_pkg::finish_rpt_t [3:0]     finish_i,
    input  rob_types_pkg::branch_fin_t           branch_fin_i,
    input  logic                                 flush_i,
    input  core_cfg_pkg::addr_t                  pred_pc_i,
    input  core_cfg_pkg::bhr_t                   pred_bhr_i,
    output logic                                 stall_o,
    output core_cfg_pkg::rob_tag_t [1:0]         dp_tag_o,
    output rob_types_pkg::commit_t [1:0]         commit_o,
    output rob_types_pkg::br_train_t             br_train_o,
    output logic                                 pred_taken_o
);

    logic [1:0] dp_ok;
    logic [1:0] commit_num;

    rob_alloc i_alloc (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .dispatch_i   (dispatch_i),
        .commit_num_i (commit_num),
        .flush_i      (flush_i),
        .stall_o      (stall_o),
        .dp_ok_o      (dp_ok),
        .dp_tag_o     (dp_tag_o)
    );

    rob i_rob (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .dispatch_i   (dispatch_i),
        .dp_ok_i      (dp_ok),
        .dp_tag_i     (dp_tag_o),
        .finish_i     (finish_i),
        .branch_fin_i (branch_fin_i),
        .flush_i      (flush_i),
        .commit_o     (commit_o),
        .commit_num_o (commit_num),
        .br_train_o   (br_train_o)
    );

    // trained by the same commit stream that leaves the core
    gshare_pht i_pht (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .train_i      (br_train_o),
        .pred_pc_i    (pred_pc_i),
        .pred_bhr_i   (pred_bhr_i),
        .pred_taken_o (pred_taken_o)
    );

endmodule

/* retire_subsys.f */
common/core_cfg_pkg.sv
common/rob_types_pkg.sv
rob/rob_alloc.sv
rob/rob.sv
hdl/gshare_pht.sv
hdl/retire_top.sv
tb/retire_tb.sv

/* rob/rob.sv */
`timescale 1ns/100ps

module rob (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  rob_types_pkg::dispatch_req_t [1:0]   dispatch_i,
    input  logic [1:0]                           dp_ok_i,
    input  core_cfg_pkg::rob_tag_t [1:0]         dp_tag_i,
    input  rob_types_pkg::finish_rpt_t [3:0]     finish_i,
    input  rob_types_pkg::branch_fin_t           branch_fin_i,
    input  logic                                 flush_i,
    output rob_types_pkg::commit_t [1:0]         commit_o,
    output logic [1:0]                           commit_num_o,
    output rob_types_pkg::br_train_t             br_train_o
);
    import core_cfg_pkg::*;

    // per-entry payload
    typedef struct packed {
        logic  is_store;
        logic  dst_valid;
        areg_t dst;
        logic  is_branch;
        addr_t pc;
        bhr_t  bhr;
        logic  taken;
        addr_t target;
    } entry_t;

    logic [ROB_NUM-1:0] valid_q;
    logic [ROB_NUM-1:0] finished_q;
    entry_t             ent_q [ROB_NUM];

    rob_tag_t head_q;
    rob_tag_t head1;
    logic     cm0;
    logic     cm1;
    logic     br0;
    logic     br1;
    rob_tag_t br_sel;

    assign head1 = head_q + rob_tag_t'(1);

    // in-order commit from the head
    always_comb begin
        cm0 = valid_q[head_q] & finished_q[head_q] & ~flush_i;
        // only one branch may train per cycle
        cm1 = cm0 & valid_q[head1] & finished_q[head1]
            & ~(ent_q[head_q].is_branch & ent_q[head1].is_branch);
        br0 = cm0 & ent_q[head_q].is_branch;
        br1 = cm1 & ent_q[head1].is_branch;
    end

    assign commit_num_o = {1'b0, cm0} + {1'b0, cm1};

    assign commit_o[0].valid    = cm0;
    assign commit_o[0].arf_we   = cm0 & ent_q[head_q].dst_valid;
    assign commit_o[0].dst      = ent_q[head_q].dst;
    assign commit_o[0].is_store = cm0 & ent_q[head_q].is_store;

    assign commit_o[1].valid    = cm1;
    assign commit_o[1].arf_we   = cm1 & ent_q[head1].dst_valid;
    assign commit_o[1].dst      = ent_q[head1].dst;
    assign commit_o[1].is_store = cm1 & ent_q[head1].is_store;

    // older committing branch goes to the predictor
    assign br_sel = br0 ? head_q : head1;

    assign br_train_o.valid  = br0 | br1;
    assign br_train_o.pc     = ent_q[br_sel].pc;
    assign br_train_o.bhr    = ent_q[br_sel].bhr;
    assign br_train_o.taken  = ent_q[br_sel].taken;
    assign br_train_o.target = ent_q[br_sel].target;

    // control state
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q    <= '0;
            finished_q <= '0;
            head_q     <= '0;
        end else begin
            head_q <= head_q + rob_tag_t'(commit_num_o);
            for (int i = 0; i < 4; i++) begin
                if (finish_i[i].valid) begin
                    finished_q[finish_i[i].tag] <= 1'b1;
                end
            end
            if (branch_fin_i.valid) begin
                finished_q[branch_fin_i.tag] <= 1'b1;
            end
            if (cm0) begin
                valid_q[head_q] <= 1'b0;
            end
            if (cm1) begin
                valid_q[head1] <= 1'b0;
            end
            // dispatch wins over a finish to the same entry
            for (int s = 0; s < 2; s++) begin
                if (dp_ok_i[s]) begin
                    valid_q[dp_tag_i[s]]    <= 1'b1;
                    finished_q[dp_tag_i[s]] <= 1'b0;
                end
            end
            // mispredict drops everything uncommitted
            if (flush_i) begin
                valid_q <= '0;
            end
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        if (branch_fin_i.valid) begin
            ent_q[branch_fin_i.tag].taken  <= branch_fin_i.taken;
            ent_q[branch_fin_i.tag].target <= branch_fin_i.target;
        end
        for (int s = 0; s < 2; s++) begin
            if (dp_ok_i[s]) begin
                ent_q[dp_tag_i[s]].is_store  <= dispatch_i[s].is_store;
                ent_q[dp_tag_i[s]].dst_valid <= dispatch_i[s].dst_valid;
                ent_q[dp_tag_i[s]].dst       <= dispatch_i[s].dst;
                ent_q[dp_tag_i[s]].is_branch <= dispatch_i[s].is_branch;
                ent_q[dp_tag_i[s]].pc        <= dispatch_i[s].pc;
                ent_q[dp_tag_i[s]].bhr       <= dispatch_i[s].bhr;
                ent_q[dp_tag_i[s]].taken     <= 1'b0;
                ent_q[dp_tag_i[s]].target    <= '0;
            end
        end
    end

endmodule

/* rob/rob_alloc.sv */
`timescale 1ns/100ps

module rob_alloc (
    input  logic                                 clk_i,
    input  logic                                 reset_i,
    input  rob_types_pkg::dispatch_req_t [1:0]   dispatch_i,
    input  logic [1:0]                           commit_num_i,
    input  logic                                 flush_i,
    output logic                                 stall_o,
    output logic [1:0]                           dp_ok_o,
    output core_cfg_pkg::rob_tag_t [1:0]         dp_tag_o
);
    import core_cfg_pkg::*;

    rob_tag_t tail_q;
    rob_cnt_t free_q;
    rob_cnt_t req_num;
    rob_cnt_t acc_num;
    rob_tag_t head;

    // all or nothing, stall when the pair does not fit
    always_comb begin
        req_num = rob_cnt_t'(dispatch_i[0].valid) + rob_cnt_t'(dispatch_i[1].valid);
        stall_o = (req_num > free_q);
    end

    // wrong-path requests in the flush cycle are dropped
    assign dp_ok_o[0] = dispatch_i[0].valid & ~stall_o & ~flush_i;
    assign dp_ok_o[1] = dispatch_i[1].valid & ~stall_o & ~flush_i;

    assign acc_num = rob_cnt_t'(dp_ok_o[0]) + rob_cnt_t'(dp_ok_o[1]);

    // slot 1 moves up to the tail when slot 0 is idle
    assign dp_tag_o[0] = tail_q;
    assign dp_tag_o[1] = dispatch_i[0].valid ? tail_q + rob_tag_t'(1) : tail_q;

    // oldest entry sits free_q slots past the tail (mod depth)
    assign head = tail_q + rob_tag_t'(free_q);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tail_q <= '0;
            free_q <= rob_cnt_t'(ROB_NUM);
        end else if (flush_i) begin
            // commit is held off during flush, so head is the commit point
            tail_q <= head;
            free_q <= rob_cnt_t'(ROB_NUM);
        end else begin
            tail_q <= tail_q + rob_tag_t'(acc_num);
            free_q <= free_q + rob_cnt_t'(commit_num_i) - acc_num;
        end
    end

endmodule

/* tb/retire_tb.sv */
`timescale 1ns/100ps

module retire_tb;
    import core_cfg_pkg::*;
    import rob_types_pkg::*;

    // words per vector line
    localparam int COLS    = 8;
    localparam int MAX_VEC = 64;

    logic                clk;
    logic                reset;
    dispatch_req_t [1:0] dispatch;
    finish_rpt_t [3:0]   finish;
    branch_fin_t         branch_fin;
    logic                flush;
    addr_t               pred_pc;
    bhr_t                pred_bhr;
    logic                stall;
    rob_tag_t [1:0]      dp_tag;
    commit_t [1:0]       commit;
    br_train_t           br_train;
    logic                pred_taken;

    logic [31:0] vec_mem [COLS*MAX_VEC];
    logic [15:0] lfsr_q;
    int          num_vec;
    int          cycle_limit;
    int          cycles = 0;
    int          errors;
    int          test_errs;
    int          checks;
    int          tests;

    // expected allocator state
    rob_tag_t    tail_exp;
    rob_tag_t    head_exp;

    retire_top i_dut (
        .clk_i        (clk),
        .reset_i      (reset),
        .dispatch_i   (dispatch),
        .finish_i     (finish),
        .branch_fin_i (branch_fin),
        .flush_i      (flush),
        .pred_pc_i    (pred_pc),
        .pred_bhr_i   (pred_bhr),
        .stall_o      (stall),
        .dp_tag_o     (dp_tag),
        .commit_o     (commit),
        .br_train_o   (br_train),
        .pred_taken_o (pred_taken)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[30:0], lfsr_q[15]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // index lands on pc[9:2] and filler takes the rest
    task automatic make_addr(input logic [7:0] idx, output addr_t a);
        logic [31:0] r;
        take_bits(24, r);
        a = {r[23:2], idx, r[1:0]};
    endtask

    function automatic string test_name(input int id);
        case (id)
            1: return "dual_commit";
            2: return "branch_pair";
            3: return "pht_train";
            4: return "flush";
            5: return "rob_full";
            default: return "unknown";
        endcase
    endfunction

    task automatic compare_val(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            test_errs++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic apply_vec(input int k);
        logic [31:0] w;
        addr_t       a;
        for (int s = 0; s < 2; s++) begin
            w = vec_mem[k*COLS+1+s];
            dispatch[s].valid     = w[27];
            dispatch[s].is_store  = w[26];
            dispatch[s].dst_valid = w[25];
            dispatch[s].is_branch = w[24];
            dispatch[s].dst       = w[20:16];
            make_addr(w[15:8], a);
            dispatch[s].pc        = a;
            dispatch[s].bhr       = w[7:0];
        end
        // one byte per unit with unit 0 leftmost
        w = vec_mem[k*COLS+3];
        for (int u = 0; u < 4; u++) begin
            finish[u].valid = w[28-8*u];
            finish[u].tag   = w[27-8*u -: 4];
        end
        w = vec_mem[k*COLS+4];
        branch_fin.valid = w[16];
        branch_fin.tag   = w[15:12];
        branch_fin.taken = w[8];
        make_addr(w[7:0], a);
        branch_fin.target = a;
        w = vec_mem[k*COLS+5];
        flush = w[16];
        make_addr(w[15:8], a);
        pred_pc  = a;
        pred_bhr = w[7:0];
    endtask

    task automatic check_vec(input int k);
        logic [31:0] e;
        logic [31:0] b;
        string       tn;
        int          older;
        e     = vec_mem[k*COLS+6];
        b     = vec_mem[k*COLS+7];
        tn    = $sformatf("%s line %0d", test_name(vec_mem[k*COLS]), k);
        older = 0;
        compare_val($sformatf("%s stall", tn), e[28], stall);
        // each request takes the tail plus the number of older requests
        for (int s = 0; s < 2; s++) begin
            if (dispatch[s].valid) begin
                if (!e[28]) begin
                    compare_val($sformatf("%s tag%0d", tn, s),
                        rob_tag_t'(tail_exp + older), dp_tag[s]);
                end
                older++;
            end
        end
        for (int s = 0; s < 2; s++) begin
            compare_val($sformatf("%s commit%0d flags", tn, s), e[26-12*s -: 3],
                {commit[s].valid, commit[s].arf_we, commit[s].is_store});
            if (e[26-12*s]) begin
                compare_val($sformatf("%s commit%0d dst", tn, s), e[20-12*s -: 5],
                    commit[s].dst);
            end
        end
        compare_val($sformatf("%s pred", tn), e[0], pred_taken);
        compare_val($sformatf("%s train valid", tn), b[20], br_train.valid);
        if (b[20]) begin
            compare_val($sformatf("%s train taken", tn), b[16], br_train.taken);
            compare_val($sformatf("%s train pc", tn), b[15:8], br_train.pc[9:2]);
            compare_val($sformatf("%s train target", tn), b[7:0], br_train.target[9:2]);
        end
        // head follows expected commits, tail follows accepted requests
        head_exp = head_exp + rob_tag_t'(e[26]) + rob_tag_t'(e[14]);
        if (flush) begin
            tail_exp = head_exp;
        end else if (!e[28]) begin
            tail_exp = rob_tag_t'(tail_exp + older);
        end
    endtask

    task automatic report_test(input int id);
        tests++;
        $display("test %0d %s done, %0d mismatches", id, test_name(id), test_errs);
        test_errs = 0;
    endtask

    initial begin
        dispatch    = '0;
        finish      = '0;
        branch_fin  = '0;
        flush       = 1'b0;
        pred_pc     = '0;
        pred_bhr    = '0;
        reset       = 1'b1;
        lfsr_q      = 16'd45;
        errors      = 0;
        test_errs   = 0;
        checks      = 0;
        tests       = 0;
        tail_exp    = '0;
        head_exp    = '0;
        cycle_limit = 50;
        $readmemh("tb/retire_vectors.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && !$isunknown(vec_mem[num_vec*COLS])) begin
            num_vec++;
        end
        cycle_limit = num_vec + 50;
        if (num_vec == 0) begin
            $display("ERROR: no test vectors were loaded");
            errors++;
        end
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        // one line per cycle and checked at the falling edge
        for (int k = 0; k < num_vec; k++) begin
            if (k > 0) begin
                @(posedge clk);
                #1;
            end
            apply_vec(k);
            #4;
            check_vec(k);
            if (k == num_vec - 1 || vec_mem[(k+1)*COLS] != vec_mem[k*COLS]) begin
                report_test(vec_mem[k*COLS]);
            end
        end
        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("ERROR: run hung, no end after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

/* tb/retire_vectors.txt */
// id disp0 disp1 finish br_fin ctl expect expect_br; disp: flags(v,st,dv,br) dst pc[9:2] bhr
// finish: 4x(valid,tag); br_fin: v tag taken tgt; ctl: flush pc bhr; expect: stall c0 dst c1 dst pred
1 a011000 c001100 00000000 00000 00000 00000000 000000
1 a031200 a041300 11000000 00000 00000 00000000 000000
1 0000000 0000000 00101312 00000 00000 00000000 000000
1 0000000 0000000 00000000 00000 00000 06015000 000000
1 0000000 0000000 00000000 00000 00000 06036040 000000
2 9002000 9002000 00000000 00000 02000 00000000 000000
2 0000000 0000000 00000000 15144 02000 00000000 000000
2 0000000 0000000 00000000 14140 02000 00000000 000000
2 0000000 0000000 00000000 00000 02000 04000000 112040
2 0000000 0000000 00000000 00000 02000 04000001 112044
3 9002000 9002000 00000000 00000 02000 00000001 000000
3 9002000 9002000 00000000 16048 02000 00000001 000000
3 0000000 0000000 00000000 1704c 02000 04000001 102048
3 0000000 0000000 00000000 18050 02000 04000001 10204c
3 0000000 0000000 00000000 19054 02000 04000000 102050
3 0000000 0000000 00000000 00000 02000 04000000 102054
3 0000000 0000000 00000000 00000 02000 00000000 000000
4 a0a0000 a0b0000 00000000 00000 02000 00000000 000000
4 0000000 0000000 1a1b0000 00000 02000 00000000 000000
4 0000000 0000000 00000000 00000 12000 00000000 000000
4 8000000 8000000 00000000 00000 02000 00000000 000000
4 8000000 8000000 00000000 00000 02000 00000000 000000
4 8000000 8000000 00000000 00000 02000 00000000 000000
4 8000000 8000000 00000000 00000 02000 00000000 000000
4 8000000 8000000 00000000 00000 02000 00000000 000000
4 8000000 8000000 00000000 00000 02000 00000000 000000
4 8000000 8000000 00000000 00000 02000 00000000 000000
4 8000000 8000000 00000000 00000 02000 00000000 000000
5 8000000 0000000 1a000000 00000 02000 10000000 000000
5 8000000 0000000 00000000 00000 02000 14000000 000000
5 8000000 0000000 00000000 00000 02000 00000000 000000
